// File: common/lsu_pkg.sv
package lsu_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // memory map
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_AW = $clog2(SRAM_WORDS); // word index width
    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] CLINT_END = 32'h0200_FFFF;
    localparam int CLINT_AW = 16;
    localparam logic [CLINT_AW-1:0] MTIME_LO_OFF = 16'hBFF8;
    localparam logic [CLINT_AW-1:0] MTIME_HI_OFF = 16'hBFFC;

    // pipeline size mask
    localparam logic [1:0] MASK_NONE = 2'd0;
    localparam logic [1:0] MASK_BYTE = 2'd1;
    localparam logic [1:0] MASK_HALF = 2'd2;
    localparam logic [1:0] MASK_WORD = 2'd3;

    // bus transfer size
    localparam logic [2:0] SIZE_B = 3'd0;
    localparam logic [2:0] SIZE_H = 3'd1;
    localparam logic [2:0] SIZE_W = 3'd2;

    localparam logic [1:0] RESP_OKAY = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;
    localparam logic [1:0] RESP_DECERR = 2'd3;

endpackage

// File: logic/addr_xbar.sv
`timescale 1ns/1ns

module addr_xbar (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ar_valid,
    input  logic [lsu_pkg::ADDR_W-1:0]   ar_addr,
    input  logic [2:0]                   ar_size,
    output logic                         ar_ready,
    output logic                         r_valid,
    output logic [lsu_pkg::DATA_W-1:0]   r_data,
    output logic [1:0]                   r_resp,
    input  logic                         r_ready,
    input  logic                         aw_valid,
    input  logic [lsu_pkg::ADDR_W-1:0]   aw_addr,
    input  logic [2:0]                   aw_size,
    output logic                         aw_ready,
    input  logic                         w_valid,
    input  logic [lsu_pkg::DATA_W-1:0]   w_data,
    input  logic [lsu_pkg::STRB_W-1:0]   w_strb,
    output logic                         w_ready,
    output logic                         b_valid,
    output logic [1:0]                   b_resp,
    input  logic                         b_ready,
    output logic                         sram_ar_valid,
    output logic [lsu_pkg::SRAM_AW-1:0]  sram_ar_addr,
    input  logic                         sram_ar_ready,
    input  logic                         sram_r_valid,
    input  logic [lsu_pkg::DATA_W-1:0]   sram_r_data,
    input  logic [1:0]                   sram_r_resp,
    output logic                         sram_r_ready,
    output logic                         sram_aw_valid,
    output logic [lsu_pkg::SRAM_AW-1:0]  sram_aw_addr,
    input  logic                         sram_aw_ready,
    output logic                         sram_w_valid,
    output logic [lsu_pkg::DATA_W-1:0]   sram_w_data,
    output logic [lsu_pkg::STRB_W-1:0]   sram_w_strb,
    input  logic                         sram_w_ready,
    input  logic                         sram_b_valid,
    input  logic [1:0]                   sram_b_resp,
    output logic                         sram_b_ready,
    output logic                         clint_ar_valid,
    output logic [lsu_pkg::CLINT_AW-1:0] clint_ar_addr,
    input  logic                         clint_ar_ready,
    input  logic                         clint_r_valid,
    input  logic [lsu_pkg::DATA_W-1:0]   clint_r_data,
    input  logic [1:0]                   clint_r_resp,
    output logic                         clint_r_ready
);

    import lsu_pkg::*;

    typedef enum logic [1:0] {SEL_SRAM, SEL_CLINT, SEL_NONE} sel_t;

    sel_t rd_sel;
    sel_t wr_sel;
    logic [ADDR_W-1:0] rd_off;
    logic [ADDR_W-1:0] wr_off;
    logic err_r_valid;
    logic err_b_valid;
    logic [1:0] err_r_resp;
    logic [1:0] err_b_resp;

    function automatic logic in_clint(input logic [ADDR_W-1:0] a);
        return (a >= CLINT_BASE) && (a <= CLINT_END);
    endfunction

    function automatic sel_t decode(input logic [ADDR_W-1:0] a, input logic [2:0] sz);
        logic [ADDR_W-1:0] off;
        off = a - SRAM_BASE;
        if (sz > SIZE_W)
            return SEL_NONE; // wider than the bus
        if (a >= SRAM_BASE && off < ADDR_W'(SRAM_WORDS * STRB_W))
            return SEL_SRAM;
        if (in_clint(a))
            return SEL_CLINT;
        return SEL_NONE;
    endfunction

    // bad size or clint write is slverr, unmapped is decerr
    function automatic logic [1:0] err_code(input logic [ADDR_W-1:0] a, input logic [2:0] sz);
        return (sz > SIZE_W || in_clint(a)) ? RESP_SLVERR : RESP_DECERR;
    endfunction

    assign rd_sel = decode(ar_addr, ar_size);
    assign wr_sel = (decode(aw_addr, aw_size) == SEL_SRAM) ? SEL_SRAM : SEL_NONE;
    assign rd_off = ar_addr - SRAM_BASE;
    assign wr_off = aw_addr - SRAM_BASE;

    assign sram_ar_valid = ar_valid & (rd_sel == SEL_SRAM);
    assign sram_ar_addr = rd_off[SRAM_AW+1:2];
    assign sram_r_ready = r_ready & (rd_sel == SEL_SRAM);
    assign clint_ar_valid = ar_valid & (rd_sel == SEL_CLINT);
    assign clint_ar_addr = ar_addr[CLINT_AW-1:0];
    assign clint_r_ready = r_ready & (rd_sel == SEL_CLINT);

    always_comb begin
        case (rd_sel)
            SEL_SRAM: begin
                ar_ready = sram_ar_ready;
                r_valid = sram_r_valid;
                r_data = sram_r_data;
                r_resp = sram_r_resp;
            end
            SEL_CLINT: begin
                ar_ready = clint_ar_ready;
                r_valid = clint_r_valid;
                r_data = clint_r_data;
                r_resp = clint_r_resp;
            end
            default: begin
                ar_ready = 1'b1; // local sink
                r_valid = err_r_valid;
                r_data = '0;
                r_resp = err_r_resp;
            end
        endcase
    end

    assign sram_aw_valid = aw_valid & (wr_sel == SEL_SRAM);
    assign sram_aw_addr = wr_off[SRAM_AW+1:2];
    assign sram_w_valid = w_valid & (wr_sel == SEL_SRAM);
    assign sram_w_data = w_data;
    assign sram_w_strb = w_strb;
    assign sram_b_ready = b_ready & (wr_sel == SEL_SRAM);

    assign aw_ready = (wr_sel == SEL_SRAM) ? sram_aw_ready : 1'b1;
    assign w_ready = (wr_sel == SEL_SRAM) ? sram_w_ready : 1'b1; // data dropped
    assign b_valid = (wr_sel == SEL_SRAM) ? sram_b_valid : err_b_valid;
    assign b_resp = (wr_sel == SEL_SRAM) ? sram_b_resp : err_b_resp;

    always_ff @(posedge clk) begin
        if (reset) begin
            err_r_valid <= 1'b0;
            err_b_valid <= 1'b0;
        end else begin
            if (ar_valid && rd_sel == SEL_NONE)
                err_r_valid <= 1'b1;
            else if (r_ready)
                err_r_valid <= 1'b0;
            // write error answered after the data beat so the master sees it
            if (w_valid && wr_sel == SEL_NONE)
                err_b_valid <= 1'b1;
            else if (b_ready)
                err_b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && rd_sel == SEL_NONE)
            err_r_resp <= err_code(ar_addr, ar_size);
        if (w_valid && wr_sel == SEL_NONE)
            err_b_resp <= err_code(aw_addr, aw_size);
    end

endmodule

// File: logic/clint_timer.sv
`timescale 1ns/1ns

module clint_timer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ar_valid,
    input  logic [lsu_pkg::CLINT_AW-1:0] ar_addr,
    output logic                         ar_ready,
    output logic                         r_valid,
    output logic [lsu_pkg::DATA_W-1:0]   r_data,
    output logic [1:0]                   r_resp,
    input  logic                         r_ready
);

    import lsu_pkg::*;

    logic [63:0] mtime;

    assign ar_ready = ~r_valid; // one read in flight
    assign r_resp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime <= '0;
            r_valid <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (ar_valid && ar_ready)
                r_valid <= 1'b1;
            else if (r_ready)
                r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            case (ar_addr)
                MTIME_LO_OFF: r_data <= mtime[31:0];
                MTIME_HI_OFF: r_data <= mtime[63:32];
                default:      r_data <= '0; // unused offsets read as zero
            endcase
        end
    end

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ready,
    input  logic                        ren,
    input  logic                        wen,
    input  logic                        sign,
    input  logic [1:0]                  mask,
    input  logic [lsu_pkg::ADDR_W-1:0]  addr,
    input  logic [lsu_pkg::DATA_W-1:0]  wdata,
    output logic [lsu_pkg::DATA_W-1:0]  rdata,
    output logic                        valid,
    output logic                        err
);

    import lsu_pkg::*;

    logic [STRB_W-1:0] strb, w_strb, sram_w_strb;
    logic [2:0] size, ar_size, aw_size;
    logic [DATA_W-1:0] wdata_lane, rd_word, w_data, r_data;
    logic [DATA_W-1:0] sram_w_data, sram_r_data, clint_r_data;
    logic [ADDR_W-1:0] ar_addr, aw_addr;
    logic [SRAM_AW-1:0] sram_ar_addr, sram_aw_addr;
    logic [CLINT_AW-1:0] clint_ar_addr;
    logic [1:0] r_resp, b_resp, sram_r_resp, sram_b_resp, clint_r_resp;
    logic done, busy;
    logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
    logic w_valid, w_ready, b_valid, b_ready;
    logic sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
    logic sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
    logic sram_b_valid, sram_b_ready;
    logic clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;

    // empty stage passes ready straight through when idle
    assign valid = (ren | wen) ? done : (ready & ~busy);

    lsu_store_align u_store_align (
        .mask(mask), .addr_lo(addr[1:0]), .wdata(wdata),
        .strb(strb), .size(size), .wdata_lane(wdata_lane)
    );

    lsu_bus_ctrl u_bus_ctrl (
        .clk(clk), .reset(reset), .ready(ready), .ren(ren), .wen(wen),
        .addr(addr), .size(size), .strb(strb), .wdata_lane(wdata_lane),
        .rd_word(rd_word), .done(done), .err(err), .busy(busy),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_size(ar_size), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_data(r_data), .r_resp(r_resp), .r_ready(r_ready),
        .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_size(aw_size), .aw_ready(aw_ready),
        .w_valid(w_valid), .w_data(w_data), .w_strb(w_strb), .w_ready(w_ready),
        .b_valid(b_valid), .b_resp(b_resp), .b_ready(b_ready)
    );

    lsu_load_extend u_load_extend (
        .rd_word(rd_word), .addr_lo(addr[1:0]), .mask(mask), .sign(sign), .rdata(rdata)
    );

    addr_xbar u_xbar (
        .clk(clk), .reset(reset),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_size(ar_size), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_data(r_data), .r_resp(r_resp), .r_ready(r_ready),
        .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_size(aw_size), .aw_ready(aw_ready),
        .w_valid(w_valid), .w_data(w_data), .w_strb(w_strb), .w_ready(w_ready),
        .b_valid(b_valid), .b_resp(b_resp), .b_ready(b_ready),
        .sram_ar_valid(sram_ar_valid), .sram_ar_addr(sram_ar_addr),
        .sram_ar_ready(sram_ar_ready), .sram_r_valid(sram_r_valid),
        .sram_r_data(sram_r_data), .sram_r_resp(sram_r_resp), .sram_r_ready(sram_r_ready),
        .sram_aw_valid(sram_aw_valid), .sram_aw_addr(sram_aw_addr),
        .sram_aw_ready(sram_aw_ready), .sram_w_valid(sram_w_valid),
        .sram_w_data(sram_w_data), .sram_w_strb(sram_w_strb), .sram_w_ready(sram_w_ready),
        .sram_b_valid(sram_b_valid), .sram_b_resp(sram_b_resp), .sram_b_ready(sram_b_ready),
        .clint_ar_valid(clint_ar_valid), .clint_ar_addr(clint_ar_addr),
        .clint_ar_ready(clint_ar_ready), .clint_r_valid(clint_r_valid),
        .clint_r_data(clint_r_data), .clint_r_resp(clint_r_resp),
        .clint_r_ready(clint_r_ready)
    );

    sram_slave u_sram (
        .clk(clk), .reset(reset),
        .ar_valid(sram_ar_valid), .ar_addr(sram_ar_addr), .ar_ready(sram_ar_ready),
        .r_valid(sram_r_valid), .r_data(sram_r_data), .r_resp(sram_r_resp),
        .r_ready(sram_r_ready),
        .aw_valid(sram_aw_valid), .aw_addr(sram_aw_addr), .aw_ready(sram_aw_ready),
        .w_valid(sram_w_valid), .w_data(sram_w_data), .w_strb(sram_w_strb),
        .w_ready(sram_w_ready),
        .b_valid(sram_b_valid), .b_resp(sram_b_resp), .b_ready(sram_b_ready)
    );

    clint_timer u_clint (
        .clk(clk), .reset(reset),
        .ar_valid(clint_ar_valid), .ar_addr(clint_ar_addr), .ar_ready(clint_ar_ready),
        .r_valid(clint_r_valid), .r_data(clint_r_data), .r_resp(clint_r_resp),
        .r_ready(clint_r_ready)
    );

endmodule

// File: logic/sram_slave.sv
`timescale 1ns/1ns

module sram_slave (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ar_valid,
    input  logic [lsu_pkg::SRAM_AW-1:0] ar_addr,
    output logic                        ar_ready,
    output logic                        r_valid,
    output logic [lsu_pkg::DATA_W-1:0]  r_data,
    output logic [1:0]                  r_resp,
    input  logic                        r_ready,
    input  logic                        aw_valid,
    input  logic [lsu_pkg::SRAM_AW-1:0] aw_addr,
    output logic                        aw_ready,
    input  logic                        w_valid,
    input  logic [lsu_pkg::DATA_W-1:0]  w_data,
    input  logic [lsu_pkg::STRB_W-1:0]  w_strb,
    output logic                        w_ready,
    output logic                        b_valid,
    output logic [1:0]                  b_resp,
    input  logic                        b_ready
);

    import lsu_pkg::*;

    logic [DATA_W-1:0] mem [SRAM_WORDS];
    logic [SRAM_AW-1:0] wr_idx;

    assign ar_ready = 1'b1;
    assign aw_ready = 1'b1;
    assign r_resp = RESP_OKAY;
    assign b_resp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            r_valid <= 1'b0;
            w_ready <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (ar_valid)
                r_valid <= 1'b1;
            else if (r_ready)
                r_valid <= 1'b0;
            w_ready <= w_valid & ~w_ready; // single-cycle ready pulse
            if (w_valid && w_ready)
                b_valid <= 1'b1;
            else if (b_ready)
                b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid)
            r_data <= mem[ar_addr];
        if (aw_valid)
            wr_idx <= aw_addr;
        if (w_valid && w_ready) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w_strb[i])
                    mem[wr_idx][i*8 +: 8] <= w_data[i*8 +: 8];
            end
        end
    end

endmodule

// File: lsu/lsu_bus_ctrl.sv
`timescale 1ns/1ns

module lsu_bus_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ready,
    input  logic                        ren,
    input  logic                        wen,
    input  logic [lsu_pkg::ADDR_W-1:0]  addr,
    input  logic [2:0]                  size,
    input  logic [lsu_pkg::STRB_W-1:0]  strb,
    input  logic [lsu_pkg::DATA_W-1:0]  wdata_lane,
    output logic [lsu_pkg::DATA_W-1:0]  rd_word,
    output logic                        done,
    output logic                        err,
    output logic                        busy,
    output logic                        ar_valid,
    output logic [lsu_pkg::ADDR_W-1:0]  ar_addr,
    output logic [2:0]                  ar_size,
    input  logic                        ar_ready,
    input  logic                        r_valid,
    input  logic [lsu_pkg::DATA_W-1:0]  r_data,
    input  logic [1:0]                  r_resp,
    output logic                        r_ready,
    output logic                        aw_valid,
    output logic [lsu_pkg::ADDR_W-1:0]  aw_addr,
    output logic [2:0]                  aw_size,
    input  logic                        aw_ready,
    output logic                        w_valid,
    output logic [lsu_pkg::DATA_W-1:0]  w_data,
    output logic [lsu_pkg::STRB_W-1:0]  w_strb,
    input  logic                        w_ready,
    input  logic                        b_valid,
    input  logic [1:0]                  b_resp,
    output logic                        b_ready
);

    import lsu_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_WDATA, ST_RESP} state_t;

    state_t state;
    logic is_wr;
    logic start;
    logic [ADDR_W-1:0] addr_q;
    logic [2:0] size_q;
    logic [STRB_W-1:0] strb_q;
    logic [DATA_W-1:0] wdata_q;

    // no restart in the cycle done is up, requester still holds enables
    assign start = ready & (ren | wen) & (state == ST_IDLE) & ~done;
    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            done <= 1'b0;
            err <= 1'b0;
        end else begin
            done <= 1'b0;
            err <= 1'b0;
            case (state)
                ST_IDLE: if (start) state <= ST_ADDR;
                ST_ADDR: begin
                    if (is_wr && aw_ready)
                        state <= ST_WDATA;
                    else if (!is_wr && ar_ready)
                        state <= ST_RESP;
                end
                ST_WDATA: if (w_ready) state <= ST_RESP;
                default: begin
                    if (is_wr ? b_valid : r_valid) begin
                        state <= ST_IDLE;
                        done <= 1'b1;
                        err <= is_wr ? (b_resp != RESP_OKAY) : (r_resp != RESP_OKAY);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_wr <= wen; // write wins if both set
            addr_q <= addr;
            size_q <= size;
            strb_q <= strb;
            wdata_q <= wdata_lane;
        end
        if (state == ST_RESP && !is_wr && r_valid)
            rd_word <= r_data;
    end

    assign ar_valid = (state == ST_ADDR) & ~is_wr;
    assign aw_valid = (state == ST_ADDR) & is_wr;
    assign w_valid = (state == ST_WDATA);
    assign ar_addr = addr_q;
    assign aw_addr = addr_q;
    assign ar_size = size_q;
    assign aw_size = size_q;
    assign w_data = wdata_q;
    assign w_strb = strb_q;
    assign r_ready = 1'b1;
    assign b_ready = 1'b1;

endmodule

// File: lsu/lsu_load_extend.sv
`timescale 1ns/1ns

module lsu_load_extend (
    input  logic [lsu_pkg::DATA_W-1:0]  rd_word,
    input  logic [1:0]                  addr_lo,
    input  logic [1:0]                  mask,
    input  logic                        sign,
    output logic [lsu_pkg::DATA_W-1:0]  rdata
);

    import lsu_pkg::*;

    logic [DATA_W-1:0] shifted;

    assign shifted = rd_word >> {addr_lo, 3'b000}; // addressed byte to lane 0

    always_comb begin
        case (mask)
            MASK_BYTE: rdata = {{24{sign & shifted[7]}}, shifted[7:0]};
            MASK_HALF: rdata = {{16{sign & shifted[15]}}, shifted[15:0]};
            MASK_WORD: rdata = shifted;
            default:   rdata = '0;
        endcase
    end

endmodule

// File: lsu/lsu_store_align.sv
`timescale 1ns/1ns

module lsu_store_align (
    input  logic [1:0]                  mask,
    input  logic [1:0]                  addr_lo,
    input  logic [lsu_pkg::DATA_W-1:0]  wdata,
    output logic [lsu_pkg::STRB_W-1:0]  strb,
    output logic [2:0]                  size,
    output logic [lsu_pkg::DATA_W-1:0]  wdata_lane
);

    import lsu_pkg::*;

    always_comb begin
        case (mask)
            MASK_BYTE: begin
                strb = 4'b0001 << addr_lo;
                size = SIZE_B;
            end
            MASK_HALF: begin
                strb = addr_lo[1] ? 4'b1100 : 4'b0011; // bit 0 ignored
                size = SIZE_H;
            end
            MASK_WORD: begin
                strb = 4'b1111;
                size = SIZE_W;
            end
            default: begin
                strb = 4'b0000; // no mask, nothing written
                size = SIZE_B;
            end
        endcase
    end

    // move data onto its byte lane
    assign wdata_lane = wdata << {addr_lo, 3'b000};

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_lsu -f src.f -o sim_lsu
out=$(./obj_dir/sim_lsu)
echo "$out"
if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: src.f
common/lsu_pkg.sv
lsu/lsu_store_align.sv
lsu/lsu_bus_ctrl.sv
lsu/lsu_load_extend.sv
logic/addr_xbar.sv
logic/sram_slave.sv
logic/clint_timer.sv
logic/lsu_top.sv
testbench/lsu_checker.sv
testbench/tb_lsu.sv

// File: testbench/lsu_checker.sv
`timescale 1ns/1ns

module lsu_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        ready,
    input  logic        ren,
    input  logic        wen,
    input  logic        sign,
    input  logic [1:0]  mask,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [31:0] rdata,
    input  logic        valid,
    input  logic        err,
    input  logic        exp_err,
    input  int          row,
    input  logic        row_end,
    output int          tests,
    output int          errors
);

    import lsu_pkg::*;

    logic [7:0] bytes_model [SRAM_WORDS*4];
    logic pending;
    logic have_lo;
    logic q_wen;
    logic q_sign;
    logic q_exp_err;
    logic [1:0] q_mask;
    logic [31:0] q_addr;
    logic [31:0] q_wdata;
    logic [31:0] last_lo;
    int row_errors;

    function automatic logic in_sram(input logic [31:0] a);
        return (a >= SRAM_BASE) && ((a - SRAM_BASE) < 32'(SRAM_WORDS * 4));
    endfunction

    // gather bytes from the addressed one upward and zero past the word end
    function automatic logic [31:0] predict_load(input logic [31:0] a, input logic [1:0] m,
                                                 input logic s);
        logic [9:0] base;
        logic [7:0] b [4];
        base = 10'(a - SRAM_BASE);
        for (int k = 0; k < 4; k++)
            b[k] = (int'(base[1:0]) + k < 4) ? bytes_model[base + 10'(k)] : 8'h00;
        case (m)
            MASK_BYTE: return {{24{s & b[0][7]}}, b[0]};
            MASK_HALF: return {{16{s & b[1][7]}}, b[1], b[0]};
            MASK_WORD: return {b[3], b[2], b[1], b[0]};
            default:   return 32'h0;
        endcase
    endfunction

    task automatic apply_store(input logic [31:0] a, input logic [1:0] m, input logic [31:0] d);
        logic [9:0] base;
        logic [31:0] lanes;
        logic [3:0] en;
        base = 10'(a - SRAM_BASE);
        lanes = d << (8 * base[1:0]);
        case (m)
            MASK_BYTE: en = 4'b0001 << base[1:0];
            MASK_HALF: en = base[1] ? 4'b1100 : 4'b0011;
            MASK_WORD: en = 4'b1111;
            default:   en = 4'b0000;
        endcase
        for (int k = 0; k < 4; k++) begin
            if (en[k])
                bytes_model[{base[9:2], 2'b00} + 10'(k)] = lanes[8*k +: 8];
        end
    endtask

    task automatic note_error();
        errors++;
        row_errors++;
    endtask

    task automatic check_result();
        logic [31:0] want;
        if (err !== q_exp_err) begin
            $display("error: test %0d err 0x%0h expected 0x%0h", row, err, q_exp_err);
            note_error();
        end
        if (q_wen) begin
            if (in_sram(q_addr))
                apply_store(q_addr, q_mask, q_wdata);
        end else if (in_sram(q_addr)) begin
            want = predict_load(q_addr, q_mask, q_sign);
            if (rdata !== want) begin
                $display("error: test %0d rdata 0x%08h expected 0x%08h", row, rdata, want);
                note_error();
            end
        end else if (q_addr == CLINT_BASE + {16'h0000, MTIME_LO_OFF}) begin
            if ($isunknown(rdata) || (have_lo && rdata <= last_lo)) begin
                $display("error: test %0d rdata 0x%08h not above previous mtime 0x%08h",
                         row, rdata, last_lo);
                note_error();
            end
            have_lo = 1'b1;
            last_lo = rdata;
        end else if (q_addr == CLINT_BASE + {16'h0000, MTIME_HI_OFF}) begin
            if (rdata !== 32'h0) begin
                $display("error: test %0d rdata 0x%08h expected 0x00000000", row, rdata);
                note_error();
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pending = 1'b0;
            have_lo = 1'b0;
        end else begin
            if (valid && pending) begin
                pending = 1'b0;
                check_result();
            end else if (!pending && ready && (ren || wen)) begin
                pending = 1'b1; // request taken this edge
                q_wen = wen;
                q_sign = sign;
                q_mask = mask;
                q_addr = addr;
                q_wdata = wdata;
                q_exp_err = exp_err;
            end else if (!pending && !ren && !wen && valid !== ready) begin
                $display("error: test %0d valid 0x%0h expected 0x%0h", row, valid, ready);
                note_error();
            end
            if (row_end) begin
                if (row_errors == 0)
                    $display("test %0d ok", row);
                else
                    $display("test %0d failed", row);
                tests++;
                row_errors = 0;
            end
        end
    end

endmodule

// File: testbench/tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu;

    import lsu_pkg::*;

    typedef enum int {OP_HOLD_LOW, OP_IDLE, OP_LOAD, OP_STORE, OP_STORE_BUSY} op_t;

    localparam int WAIT_LIMIT = 40;

    logic clk;
    logic reset;
    logic ready;
    logic ren;
    logic wen;
    logic sign;
    logic [1:0] mask;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic valid;
    logic err;
    logic exp_err;
    logic row_end;
    logic [31:0] lfsr_state;
    int row;
    int tests;
    int errors;
    bit timed_out;

    op_t t_op[$];
    logic [1:0] t_mask[$];
    logic t_sign[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_data[$];
    logic t_rnd[$];
    logic t_err[$];

    lsu_top i_dut (
        .clk(clk), .reset(reset), .ready(ready), .ren(ren), .wen(wen), .sign(sign),
        .mask(mask), .addr(addr), .wdata(wdata), .rdata(rdata), .valid(valid), .err(err)
    );

    lsu_checker u_checker (
        .clk(clk), .reset(reset), .ready(ready), .ren(ren), .wen(wen), .sign(sign),
        .mask(mask), .addr(addr), .wdata(wdata), .rdata(rdata), .valid(valid), .err(err),
        .exp_err(exp_err), .row(row), .row_end(row_end), .tests(tests), .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = 32'h0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[b] = lfsr_state[0];
        end
        return w;
    endfunction

    task automatic add_row(input op_t op, input logic [1:0] m, input logic s,
                           input logic [31:0] a, input logic [31:0] d, input logic rnd,
                           input logic e);
        t_op.push_back(op);
        t_mask.push_back(m);
        t_sign.push_back(s);
        t_addr.push_back(a);
        t_data.push_back(d);
        t_rnd.push_back(rnd);
        t_err.push_back(e);
    endtask

    task automatic build_table();
        add_row(OP_HOLD_LOW, MASK_NONE, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        add_row(OP_IDLE, MASK_NONE, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        // word round trips
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h8000_0000, 32'h0, 1'b1, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h8000_0000, 32'h0, 1'b0, 1'b0);
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h8000_0104, 32'h0, 1'b1, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h8000_0104, 32'h0, 1'b0, 1'b0);
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h8000_03FC, 32'h0, 1'b1, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h8000_03FC, 32'h0, 1'b0, 1'b0);
        // partial stores merging
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h8000_0020, 32'h0, 1'b1, 1'b0);
        add_row(OP_STORE, MASK_BYTE, 1'b0, 32'h8000_0020, 32'h0, 1'b1, 1'b0);
        add_row(OP_STORE, MASK_BYTE, 1'b0, 32'h8000_0021, 32'h0, 1'b1, 1'b0);
        add_row(OP_STORE, MASK_BYTE, 1'b0, 32'h8000_0023, 32'h0, 1'b1, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h8000_0020, 32'h0, 1'b0, 1'b0);
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h8000_0024, 32'h0, 1'b1, 1'b0);
        add_row(OP_STORE, MASK_BYTE, 1'b0, 32'h8000_0026, 32'h0, 1'b1, 1'b0);
        add_row(OP_STORE, MASK_HALF, 1'b0, 32'h8000_0024, 32'h0, 1'b1, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h8000_0024, 32'h0, 1'b0, 1'b0);
        add_row(OP_STORE, MASK_HALF, 1'b0, 32'h8000_0026, 32'h0, 1'b1, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h8000_0024, 32'h0, 1'b0, 1'b0);
        // narrow loads, both signs
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h8000_0030, 32'h80F7_7F81, 1'b0, 1'b0);
        for (int i = 0; i < 8; i++)
            add_row(OP_LOAD, MASK_BYTE, i[0], 32'h8000_0030 + 32'(i / 2), 32'h0, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++)
            add_row(OP_LOAD, MASK_HALF, i[0], 32'h8000_0030 + 32'(i & 2), 32'h0, 1'b0, 1'b0);
        // mtime
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h0200_BFF8, 32'h0, 1'b0, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h0200_BFF8, 32'h0, 1'b0, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h0200_BFFC, 32'h0, 1'b0, 1'b0);
        // error responses
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h1000_0000, 32'h0, 1'b0, 1'b1);
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h1000_0004, 32'h0, 1'b1, 1'b1);
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h0200_BFF8, 32'h0, 1'b1, 1'b1);
        add_row(OP_STORE, MASK_WORD, 1'b0, 32'h8000_0400, 32'h0, 1'b1, 1'b1);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h8000_0000, 32'h0, 1'b0, 1'b0);
        add_row(OP_IDLE, MASK_NONE, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        add_row(OP_STORE_BUSY, MASK_WORD, 1'b0, 32'h8000_0040, 32'h0, 1'b1, 1'b0);
        add_row(OP_LOAD, MASK_WORD, 1'b0, 32'h8000_0040, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic run_row(input int idx);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        @(negedge clk);
        row = idx;
        ready = (t_op[idx] != OP_HOLD_LOW);
        ren = (t_op[idx] == OP_LOAD);
        wen = (t_op[idx] == OP_STORE) || (t_op[idx] == OP_STORE_BUSY);
        mask = t_mask[idx];
        sign = t_sign[idx];
        addr = t_addr[idx];
        wdata = t_rnd[idx] ? random_word() : t_data[idx];
        exp_err = t_err[idx];
        if (!ren && !wen) begin
            repeat (3) @(posedge clk);
            seen = 1'b1;
        end else begin
            if (t_op[idx] == OP_STORE_BUSY) begin
                repeat (2) @(posedge clk);
                @(negedge clk);
                wdata = ~wdata; // must not start a second write
            end
            while (!seen && cycles < WAIT_LIMIT) begin
                @(posedge clk);
                seen = valid;
                cycles++;
            end
        end
        if (!seen) begin
            $display("timeout: test %0d saw no valid within %0d cycles", idx, WAIT_LIMIT);
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
            ren = 1'b0;
            wen = 1'b0;
            row_end = 1'b1;
            @(negedge clk);
            row_end = 1'b0;
        end
    endtask

    initial begin
        reset = 1'b1;
        ready = 1'b0;
        ren = 1'b0;
        wen = 1'b0;
        sign = 1'b0;
        mask = 2'd0;
        addr = 32'h0;
        wdata = 32'h0;
        exp_err = 1'b0;
        row_end = 1'b0;
        row = 0;
        timed_out = 1'b0;
        lfsr_state = 32'd55;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < t_op.size() && !timed_out; i++)
            run_row(i);
        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d errors", tests, errors);
        if (!timed_out && errors == 0 && tests == t_op.size()) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
